//--- verilog/csi_pkg.sv
// Shared types and constants for the CSI-2 byte-clock receive pipeline
// Referenced by scoped names from every stage and the bench
`default_nettype none

package csi_pkg;

    // CSI-2 data type codes
    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW10       = 6'h2B;

    localparam int COORD_W = 11;
    localparam int SUM_W   = 24;
    localparam int COUNT_W = 20;

    // Parity masks over header bits 23:0, entry i gives ECC bit i
    localparam logic [5:0][23:0] ECC_MASK = {
        24'hEFFC00, 24'hDF03F0, 24'hB8E38E, 24'h749A6D, 24'hF2555B, 24'hF12CB7
    };

    typedef struct packed {
        logic [1:0] vc;
        logic [5:0] dt;
    } data_id_t;

    // Fields listed high to low, byte 0 of the lane lands in bits 7:0
    typedef struct packed {
        logic [7:0]  ecc;
        logic [15:0] word_count;
        data_id_t    data_id;
    } long_hdr_t;

    typedef struct packed {
        logic [7:0]  ecc;
        logic [15:0] data_field; // Frame number for FS/FE
        data_id_t    data_id;
    } short_hdr_t;

    typedef union packed {
        long_hdr_t  long_hdr;
        short_hdr_t short_hdr;
    } csi_header_u;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } lane_byte_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last;
    } payload_byte_t;

    typedef struct packed {
        logic        frame_start;
        logic        frame_end;
        logic [15:0] frame_number;
    } frame_event_t;

    typedef struct packed {
        logic        pixel_valid;
        logic [9:0]  pixel;
        logic        line_end;
        logic        frame_start;
        logic        frame_end;
        logic [15:0] frame_number;
    } video_beat_t;

    typedef struct packed {
        logic [COORD_W-1:0] x_start;
        logic [COORD_W-1:0] x_end;
        logic [COORD_W-1:0] y_start;
        logic [COORD_W-1:0] y_end;
    } crop_window_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } metering_t;

endpackage

`default_nettype wire

//--- verilog/csi_header_decoder.sv
// Splits the lane byte stream into packets, checks header ECC, emits
// frame events and forwards RAW10 payload bytes with a last marker
`timescale 1ns/1ps
`default_nettype none

module csi_header_decoder (
    input  wire                        mipi_byte_clock,
    input  wire                        mipi_byte_reset_n,
    input  wire                        sync_i,
    input  csi_pkg::lane_byte_t        lane_i,
    output csi_pkg::payload_byte_t     payload_o,
    output csi_pkg::frame_event_t      frame_event_o,
    output logic                       ecc_error_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HEADER,
        S_PAYLOAD,
        S_CRC
    } state_e;

    state_e               state_q;
    logic [15:0]          count_q;  // Header index, payload left or CRC left
    logic                 raw_q;    // Current long packet is RAW10
    logic [23:0]          hdr_q;    // First three header bytes
    csi_pkg::csi_header_u hdr_w;
    logic [5:0]           ecc_calc;
    logic                 hdr_ok;
    logic                 is_long;
    logic [5:0]           dt_w;

    always_comb begin
        hdr_w = {lane_i.data, hdr_q};
        for (int i = 0; i < 6; i++) begin
            ecc_calc[i] = ^(hdr_q & csi_pkg::ECC_MASK[i]);
        end
        hdr_ok  = hdr_w.long_hdr.ecc == {2'b00, ecc_calc}; // Top two bits must be zero
        dt_w    = hdr_w.long_hdr.data_id.dt;
        is_long = dt_w[5:4] != 2'b00; // 0x00-0x0F are short packets
    end

    // Header bytes shift in from the top, byte 0 ends up lowest
    always_ff @(posedge mipi_byte_clock) begin
        if (state_q == S_HEADER && lane_i.valid && !sync_i) begin
            hdr_q <= {lane_i.data, hdr_q[23:8]};
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state_q       <= S_IDLE;
            count_q       <= '0;
            raw_q         <= 1'b0;
            payload_o     <= '0;
            frame_event_o <= '0;
            ecc_error_o   <= 1'b0;
        end else begin
            payload_o.valid           <= 1'b0;
            payload_o.last            <= 1'b0;
            frame_event_o.frame_start <= 1'b0;
            frame_event_o.frame_end   <= 1'b0;
            ecc_error_o               <= 1'b0;

            if (sync_i) begin
                state_q <= S_HEADER; // SoT done, header follows
                count_q <= '0;
            end else if (lane_i.valid) begin
                case (state_q)
                    S_HEADER: begin
                        count_q <= count_q + 16'd1;
                        if (count_q == 16'd3) begin
                            if (!hdr_ok) begin
                                ecc_error_o <= 1'b1;
                                state_q     <= S_IDLE; // Drop until next sync
                            end else if (is_long) begin
                                raw_q <= dt_w == csi_pkg::DT_RAW10;
                                if (hdr_w.long_hdr.word_count == 16'd0) begin
                                    state_q <= S_CRC;
                                    count_q <= 16'd2;
                                end else begin
                                    state_q <= S_PAYLOAD;
                                    count_q <= hdr_w.long_hdr.word_count;
                                end
                            end else begin
                                if (dt_w == csi_pkg::DT_FRAME_START ||
                                    dt_w == csi_pkg::DT_FRAME_END) begin
                                    frame_event_o.frame_start  <=
                                        dt_w == csi_pkg::DT_FRAME_START;
                                    frame_event_o.frame_end    <=
                                        dt_w == csi_pkg::DT_FRAME_END;
                                    frame_event_o.frame_number <=
                                        hdr_w.short_hdr.data_field;
                                end
                                state_q <= S_IDLE;
                            end
                        end
                    end
                    S_PAYLOAD: begin
                        payload_o.valid <= raw_q; // Other long types vanish here
                        payload_o.data  <= lane_i.data;
                        payload_o.last  <= count_q == 16'd1;
                        count_q         <= count_q - 16'd1;
                        if (count_q == 16'd1) begin
                            state_q <= S_CRC;
                            count_q <= 16'd2;
                        end
                    end
                    S_CRC: begin
                        count_q <= count_q - 16'd1; // CRC is not checked
                        if (count_q == 16'd1) begin
                            state_q <= S_IDLE;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/raw10_unpacker.sv
// Unpacks RAW10 five-byte groups into 10-bit pixels and merges the
// frame start/end events into the same beat stream
`timescale 1ns/1ps
`default_nettype none

module raw10_unpacker (
    input  wire                        mipi_byte_clock,
    input  wire                        mipi_byte_reset_n,
    input  csi_pkg::payload_byte_t     payload_i,
    input  csi_pkg::frame_event_t      frame_event_i,
    output csi_pkg::video_beat_t       video_o
);

    logic [2:0]            byte_idx_q;
    logic [3:0][7:0]       msb_q;      // Bits 9:2 of pixels 0..3
    logic [2:0][9:0]       shift_q;    // Pixels 1..3 waiting to drain
    logic [1:0]            pend_q;
    logic                  last_q;     // Group closes the packet
    csi_pkg::frame_event_t slot_q;
    logic                  slot_full_q;
    logic                  group_done;
    logic                  new_event;

    assign group_done = payload_i.valid && byte_idx_q == 3'd4;
    assign new_event  = frame_event_i.frame_start || frame_event_i.frame_end;

    always_ff @(posedge mipi_byte_clock) begin
        if (payload_i.valid && byte_idx_q != 3'd4) begin
            msb_q[byte_idx_q[1:0]] <= payload_i.data;
        end
        if (group_done) begin
            shift_q <= {{msb_q[3], payload_i.data[7:6]},
                        {msb_q[2], payload_i.data[5:4]},
                        {msb_q[1], payload_i.data[3:2]}};
        end else if (pend_q != 2'd0) begin
            shift_q <= {10'd0, shift_q[2:1]};
        end
        if (new_event) begin
            slot_q <= frame_event_i;
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            byte_idx_q  <= '0;
            pend_q      <= '0;
            last_q      <= 1'b0;
            slot_full_q <= 1'b0;
            video_o     <= '0;
        end else begin
            video_o.pixel_valid <= 1'b0;
            video_o.line_end    <= 1'b0;
            video_o.frame_start <= 1'b0;
            video_o.frame_end   <= 1'b0;

            if (payload_i.valid) begin
                byte_idx_q <= (byte_idx_q == 3'd4 || payload_i.last) ? 3'd0 :
                              byte_idx_q + 3'd1;
            end

            if (group_done) begin
                // Pixel 0 goes straight out, the rest drain behind it
                video_o.pixel_valid <= 1'b1;
                video_o.pixel       <= {msb_q[0], payload_i.data[1:0]};
                pend_q              <= 2'd3;
                last_q              <= payload_i.last;
            end else if (pend_q != 2'd0) begin
                video_o.pixel_valid <= 1'b1;
                video_o.pixel       <= shift_q[0];
                video_o.line_end    <= last_q && pend_q == 2'd1;
                pend_q              <= pend_q - 2'd1;
            end else if (slot_full_q) begin
                video_o.frame_start  <= slot_q.frame_start; // Idle cycle, event out
                video_o.frame_end    <= slot_q.frame_end;
                video_o.frame_number <= slot_q.frame_number;
                slot_full_q          <= 1'b0;
            end

            if (new_event) begin
                slot_full_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/bayer_metering.sv
// Passes the pixel stream through and averages the RGGB colour sites
// of each frame, result valid on meter_valid_o after the divider runs
`timescale 1ns/1ps
`default_nettype none

module bayer_metering (
    input  wire                        mipi_byte_clock,
    input  wire                        mipi_byte_reset_n,
    input  csi_pkg::video_beat_t       video_i,
    output csi_pkg::video_beat_t       video_o,
    output csi_pkg::metering_t         metering_o,
    output logic                       meter_valid_o
);

    localparam int SW = csi_pkg::SUM_W;
    localparam int CW = csi_pkg::COUNT_W;

    logic                x_odd_q;
    logic                y_odd_q;
    logic [1:0]          site;    // 0 red, 1 green, 2 blue
    logic [2:0][SW-1:0]  sum_q;
    logic [2:0][CW-1:0]  cnt_q;
    logic [2:0][SW-1:0]  lat_sum_q;
    logic [2:0][CW-1:0]  lat_cnt_q;
    logic                busy_q;
    logic [1:0]          colour_q;
    logic [4:0]          step_q;
    logic [SW-1:0]       quo_q;   // Dividend shifts out, quotient shifts in
    logic [CW-1:0]       rem_q;
    logic [1:0][7:0]     res_q;   // Red and green wait for blue
    logic [CW:0]         trial;
    logic [CW:0]         diff;
    logic                fits;
    logic [SW-1:0]       next_quo;
    logic [CW-1:0]       next_rem;
    logic [7:0]          sat;

    always_comb begin
        site     = y_odd_q ? (x_odd_q ? 2'd2 : 2'd1) : (x_odd_q ? 2'd1 : 2'd0);
        trial    = {rem_q, quo_q[SW-1]};
        diff     = trial - {1'b0, lat_cnt_q[colour_q]};
        fits     = trial >= {1'b0, lat_cnt_q[colour_q]};
        next_quo = {quo_q[SW-2:0], fits};
        next_rem = fits ? diff[CW-1:0] : trial[CW-1:0];
        if (lat_cnt_q[colour_q] == '0) begin
            sat = 8'd0; // Empty site
        end else if (next_quo > SW'(255)) begin
            sat = 8'd255;
        end else begin
            sat = next_quo[7:0];
        end
    end

    // Divider data path
    always_ff @(posedge mipi_byte_clock) begin
        if (video_i.frame_end) begin
            lat_sum_q <= sum_q;
            lat_cnt_q <= cnt_q;
            quo_q     <= sum_q[0];
            rem_q     <= '0;
        end else if (busy_q) begin
            if (step_q == 5'(SW - 1) && colour_q != 2'd2) begin
                quo_q <= lat_sum_q[colour_q + 2'd1]; // Next colour
                rem_q <= '0;
            end else begin
                quo_q <= next_quo;
                rem_q <= next_rem;
            end
        end
        if (busy_q && step_q == 5'(SW - 1) && colour_q != 2'd2) begin
            res_q[colour_q[0]] <= sat;
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            video_o       <= '0;
            x_odd_q       <= 1'b0;
            y_odd_q       <= 1'b0;
            sum_q         <= '0;
            cnt_q         <= '0;
            busy_q        <= 1'b0;
            colour_q      <= '0;
            step_q        <= '0;
            metering_o    <= '0;
            meter_valid_o <= 1'b0;
        end else begin
            video_o       <= video_i; // One cycle pass-through
            meter_valid_o <= 1'b0;

            if (video_i.frame_start) begin
                x_odd_q <= 1'b0;
                y_odd_q <= 1'b0;
                sum_q   <= '0;
                cnt_q   <= '0;
            end else if (video_i.pixel_valid) begin
                sum_q[site] <= sum_q[site] + SW'(video_i.pixel[9:2]);
                cnt_q[site] <= cnt_q[site] + CW'(1);
                x_odd_q     <= video_i.line_end ? 1'b0 : !x_odd_q;
                if (video_i.line_end) begin
                    y_odd_q <= !y_odd_q;
                end
            end

            if (video_i.frame_end) begin
                busy_q   <= 1'b1;
                colour_q <= 2'd0;
                step_q   <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 5'd1;
                if (step_q == 5'(SW - 1)) begin
                    step_q   <= '0;
                    colour_q <= colour_q + 2'd1;
                    if (colour_q == 2'd2) begin
                        busy_q        <= 1'b0;
                        meter_valid_o <= 1'b1;
                        metering_o    <= {res_q[0], res_q[1], sat};
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/pixel_crop.sv
// Drops pixels outside the crop window, window latched at frame start
// line_end follows the last kept pixel of each window row
`timescale 1ns/1ps
`default_nettype none

module pixel_crop (
    input  wire                        mipi_byte_clock,
    input  wire                        mipi_byte_reset_n,
    input  csi_pkg::crop_window_t      window_i,
    input  csi_pkg::video_beat_t       video_i,
    output csi_pkg::video_beat_t       video_o
);

    logic [csi_pkg::COORD_W-1:0] x_q;
    logic [csi_pkg::COORD_W-1:0] y_q;
    logic [csi_pkg::COORD_W-1:0] x_last;
    csi_pkg::crop_window_t       win_q;
    logic                        x_in;
    logic                        y_in;
    logic                        keep;

    always_comb begin
        x_last = win_q.x_end - 1'b1;
        x_in   = x_q >= win_q.x_start && x_q < win_q.x_end;
        y_in   = y_q >= win_q.y_start && y_q < win_q.y_end;
        keep   = video_i.pixel_valid && x_in && y_in;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_q     <= '0;
            y_q     <= '0;
            win_q   <= '0;
            video_o <= '0;
        end else begin
            video_o.pixel_valid  <= keep;
            video_o.pixel        <= video_i.pixel;
            // Short lines end early on their own line_end
            video_o.line_end     <= keep && (video_i.line_end || x_q == x_last);
            video_o.frame_start  <= video_i.frame_start;
            video_o.frame_end    <= video_i.frame_end;
            video_o.frame_number <= video_i.frame_number;

            if (video_i.frame_start) begin
                x_q   <= '0;
                y_q   <= '0;
                win_q <= window_i;
            end else if (video_i.pixel_valid) begin
                if (video_i.line_end) begin
                    x_q <= '0;
                    y_q <= y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/camera_rx.sv
// Top level of the byte-clock receive path
// Decoder, RAW10 unpacker, metering and crop in one chain
`timescale 1ns/1ps
`default_nettype none

module camera_rx (
    input  wire                        mipi_byte_clock,
    input  wire                        mipi_byte_reset_n,
    input  wire                        sync_i,
    input  csi_pkg::lane_byte_t        lane_i,
    input  csi_pkg::crop_window_t      window_i,
    output csi_pkg::video_beat_t       video_o,
    output csi_pkg::metering_t         metering_o,
    output logic                       meter_valid_o,
    output logic                       ecc_error_o
);

    csi_pkg::payload_byte_t payload;
    csi_pkg::frame_event_t  frame_event;
    csi_pkg::video_beat_t   unpacked;
    csi_pkg::video_beat_t   metered;

    csi_header_decoder header_decoder (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .sync_i            (sync_i),
        .lane_i            (lane_i),
        .payload_o         (payload),
        .frame_event_o     (frame_event),
        .ecc_error_o       (ecc_error_o)
    );

    raw10_unpacker unpacker (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .payload_i         (payload),
        .frame_event_i     (frame_event),
        .video_o           (unpacked)
    );

    bayer_metering metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .video_i           (unpacked),
        .video_o           (metered),
        .metering_o        (metering_o),
        .meter_valid_o     (meter_valid_o)
    );

    pixel_crop crop (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .window_i          (window_i),
        .video_i           (metered),
        .video_o           (video_o)
    );

endmodule

`default_nettype wire

//--- bench/csi_lane_driver.sv
// Bench driver that builds CSI-2 packets with header ECC and RAW10 packing
// The testbench calls its tasks, bytes change on the falling clock edge
`timescale 1ns/1ps
`default_nettype none

module csi_lane_driver (
    input  wire                 mipi_byte_clock,
    output logic                sync_o,
    output csi_pkg::lane_byte_t lane_o
);

    localparam int LINE_W = 16;

    logic [7:0] payload_buf [0:255];

    initial begin
        sync_o = 1'b0;
        lane_o = '0;
    end

    // CSI-2 parity table, d[0] is bit 0 of the data identifier
    function automatic logic [7:0] header_ecc(input logic [23:0] d);
        logic [7:0] p;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18]
             ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19]
             ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
             ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        p[7:6] = 2'b00;
        return p;
    endfunction

    // Entered on a falling edge, leaves on the falling edge after the byte
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = $urandom % 3;
        lane_o.valid = 1'b0;
        repeat (gap) @(negedge mipi_byte_clock);
        lane_o.data  = b;
        lane_o.valid = 1'b1;
        @(negedge mipi_byte_clock);
    endtask

    task automatic send_header(input logic [23:0] hdr, input logic [31:0] flip_mask);
        logic [31:0] word;
        word = {header_ecc(hdr), hdr} ^ flip_mask;
        lane_o.valid = 1'b0;
        repeat (2) @(negedge mipi_byte_clock); // LP gap between packets
        sync_o = 1'b1;
        @(negedge mipi_byte_clock);
        sync_o = 1'b0;
        for (int i = 0; i < 4; i++) begin
            send_byte(word[8*i +: 8]);
        end
    endtask

    task automatic send_short(input logic [5:0] dt, input logic [15:0] data_field);
        send_header({data_field, 2'b00, dt}, '0);
        lane_o.valid = 1'b0;
    endtask

    task automatic fill_random_payload(input int n);
        for (int i = 0; i < n; i++) begin
            payload_buf[i] = 8'($urandom);
        end
    endtask

    task automatic send_long(input logic [5:0] dt, input logic [15:0] wc,
                             input logic [31:0] flip_mask);
        send_header({wc, 2'b00, dt}, flip_mask);
        for (int i = 0; i < wc; i++) begin
            send_byte(payload_buf[i]);
        end
        send_byte(8'($urandom)); // CRC bytes, never checked
        send_byte(8'($urandom));
        lane_o.valid = 1'b0;
    endtask

    // Four pixels per five bytes, low bit pairs packed into the fifth
    task automatic send_raw10_line(input logic [LINE_W-1:0][9:0] pix,
                                   input logic [31:0] flip_mask);
        for (int g = 0; g < LINE_W / 4; g++) begin
            for (int k = 0; k < 4; k++) begin
                payload_buf[5*g + k] = pix[4*g + k][9:2];
            end
            payload_buf[5*g + 4] = {pix[4*g + 3][1:0], pix[4*g + 2][1:0],
                                    pix[4*g + 1][1:0], pix[4*g][1:0]};
        end
        send_long(csi_pkg::DT_RAW10, 16'(LINE_W * 5 / 4), flip_mask);
    endtask

endmodule

`default_nettype wire

//--- bench/camera_rx_tb.sv
// Testbench for camera_rx that sends CSI-2 frames through the lane driver
// Output beats are checked against a pixel scoreboard and a metering model
`timescale 1ns/1ps
`default_nettype none

module camera_rx_tb;

    localparam int W = 16;
    localparam int H = 8;
    localparam int LINE_BYTES  = 4 + W * 5 / 4 + 2;
    // 5 frames of two short packets, 25 lines, one 40-byte foreign packet
    localparam int TOTAL_BYTES = 10 * 4 + 25 * LINE_BYTES + (4 + 40 + 2);
    localparam int TIMEOUT     = 4 * TOTAL_BYTES + 2000;

    logic                  mipi_byte_clock;
    logic                  mipi_byte_reset_n;
    logic                  sync;
    csi_pkg::lane_byte_t   lane;
    csi_pkg::crop_window_t window;
    csi_pkg::video_beat_t  video;
    csi_pkg::metering_t    metering;
    logic                  meter_valid;
    logic                  ecc_error;

    logic [10:0]           pix_q[$];  // {line_end, pixel}
    logic [17:0]           evt_q[$];  // {frame_start, frame_end, frame_number}
    csi_pkg::metering_t    meter_q[$];
    logic [10:0]           exp_pix;
    logic [17:0]           exp_evt;
    csi_pkg::metering_t    exp_meter;
    int errors, tests_passed, tests_failed, cycles, ecc_seen, meter_seen;

    camera_rx dut (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .sync_i            (sync),
        .lane_i            (lane),
        .window_i          (window),
        .video_o           (video),
        .metering_o        (metering),
        .meter_valid_o     (meter_valid),
        .ecc_error_o       (ecc_error)
    );

    csi_lane_driver driver (
        .mipi_byte_clock (mipi_byte_clock),
        .sync_o          (sync),
        .lane_o          (lane)
    );

    initial begin
        mipi_byte_clock = 1'b0;
        forever #10 mipi_byte_clock = ~mipi_byte_clock;
    end

    // Every output beat checked half a cycle after it changes
    always @(negedge mipi_byte_clock) begin
        if (mipi_byte_reset_n) begin
            if (video.pixel_valid) begin
                assert (pix_q.size() != 0) else begin
                    $display("unexpected pixel %h came out with nothing queued", video.pixel);
                    errors++;
                end
                if (pix_q.size() != 0) begin
                    exp_pix = pix_q.pop_front();
                    assert (video.pixel == exp_pix[9:0]) else begin
                        $display("error video_o.pixel got %h expected %h",
                                 video.pixel, exp_pix[9:0]);
                        errors++;
                    end
                    assert (video.line_end == exp_pix[10]) else begin
                        $display("error video_o.line_end got %h expected %h",
                                 video.line_end, exp_pix[10]);
                        errors++;
                    end
                end
            end
            assert (video.pixel_valid || !video.line_end) else begin
                $display("line_end came out on a beat without a pixel");
                errors++;
            end
            if (video.frame_start || video.frame_end) begin
                exp_evt = (evt_q.size() != 0) ? evt_q.pop_front() : '0;
                assert (exp_evt ==
                        {video.frame_start, video.frame_end, video.frame_number}) else begin
                    $display("error video_o frame event got %h expected %h",
                             {video.frame_start, video.frame_end, video.frame_number}, exp_evt);
                    errors++;
                end
            end
            if (meter_valid) begin
                assert (meter_q.size() != 0) else begin
                    $display("meter_valid_o pulsed with no frame end pending");
                    errors++;
                end
                if (meter_q.size() != 0) begin
                    exp_meter = meter_q.pop_front();
                    assert (metering == exp_meter) else begin
                        $display("error metering_o got %h expected %h", metering, exp_meter);
                        errors++;
                    end
                end
                meter_seen++;
            end
            if (ecc_error) begin
                ecc_seen++;
            end
        end
    end

    task automatic set_window(input int xs, input int xe, input int ys, input int ye);
        window.x_start = 11'(xs);
        window.x_end   = 11'(xe);
        window.y_start = 11'(ys);
        window.y_end   = 11'(ye);
    endtask

    // Sends one frame with a corrupted header on bad_line
    // and a type 0x12 packet after frame start when other_pkt is set
    task automatic run_frame(input string name, input logic [15:0] fnum, input int lines,
                             input int bad_line, input logic other_pkt);
        logic [W-1:0][9:0] pix;
        int sum [3];
        int cnt [3];
        int avg [3];
        int row, site, errors_before, ecc_before, meter_target;
        logic keep;
        errors_before = errors;
        ecc_before    = ecc_seen;
        meter_target  = meter_seen + 1;
        row           = 0;
        for (int s = 0; s < 3; s++) begin
            sum[s] = 0;
            cnt[s] = 0;
        end
        evt_q.push_back({2'b10, fnum});
        driver.send_short(csi_pkg::DT_FRAME_START, fnum);
        if (other_pkt) begin
            driver.fill_random_payload(40);
            driver.send_long(6'h12, 16'd40, '0);
        end
        for (int l = 0; l < lines; l++) begin
            for (int x = 0; x < W; x++) begin
                pix[x] = 10'($urandom);
            end
            if (l == bad_line) begin
                driver.send_raw10_line(pix, 32'd1 << ($urandom % 32));
            end else begin
                for (int x = 0; x < W; x++) begin
                    site = (row % 2) + (x % 2); // Red 0, green 1, blue 2
                    sum[site] += pix[x][9:2];
                    cnt[site]++;
                    keep = x >= window.x_start && x < window.x_end &&
                           row >= window.y_start && row < window.y_end;
                    if (keep) begin
                        pix_q.push_back({(x == W - 1 || x == window.x_end - 1), pix[x]});
                    end
                end
                row++;
                driver.send_raw10_line(pix, '0);
            end
        end
        for (int s = 0; s < 3; s++) begin
            avg[s] = (cnt[s] == 0) ? 0 : sum[s] / cnt[s];
        end
        meter_q.push_back({8'(avg[0]), 8'(avg[1]), 8'(avg[2])});
        evt_q.push_back({2'b01, fnum});
        driver.send_short(csi_pkg::DT_FRAME_END, fnum);
        wait (meter_seen == meter_target);
        assert (pix_q.size() == 0 && evt_q.size() == 0) else begin
            $display("%s: %0d pixels and %0d frame events never came out",
                     name, pix_q.size(), evt_q.size());
            errors++;
        end
        assert (ecc_seen - ecc_before == ((bad_line >= 0) ? 1 : 0)) else begin
            $display("error ecc_error_o pulses got %h expected %h",
                     ecc_seen - ecc_before, (bad_line >= 0) ? 1 : 0);
            errors++;
        end
        pix_q.delete();
        evt_q.delete();
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge mipi_byte_clock);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(99));
        mipi_byte_reset_n = 1'b0;
        set_window(0, W, 0, H);
        repeat (3) @(negedge mipi_byte_clock);
        assert (!video.pixel_valid && !video.line_end && !video.frame_start &&
                !video.frame_end && !meter_valid && !ecc_error) else begin
            $display("outputs are not idle while reset is held");
            errors++;
        end
        mipi_byte_reset_n = 1'b1;
        repeat (2) @(negedge mipi_byte_clock);
        run_frame("frame_events", 16'd5, 0, -1, 1'b0);
        run_frame("raw10_full_window", 16'd6, H, -1, 1'b0);
        set_window(3, 11, 2, 6);
        run_frame("crop_window", 16'd7, H, -1, 1'b0);
        set_window(0, W, 0, H);
        run_frame("ecc_error_drop", 16'd8, H, 2, 1'b0);
        run_frame("other_data_type", 16'd9, 1, -1, 1'b1);
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- camera_rx.f
verilog/csi_pkg.sv
verilog/csi_header_decoder.sv
verilog/raw10_unpacker.sv
verilog/bayer_metering.sv
verilog/pixel_crop.sv
verilog/camera_rx.sv
bench/csi_lane_driver.sv
bench/camera_rx_tb.sv
